// ==== include/led_panel_settings.svh ====
`ifndef LED_PANEL_SETTINGS_SVH
`define LED_PANEL_SETTINGS_SVH

// panel segments scanned in parallel
`define LP_SEGMENTS 2

// rows per segment and columns per row
`define LP_ROWS 8
`define LP_COLUMNS 32

// bits per colour channel
`define LP_BITDEPTH 8

// show time of the lsb plane in sysclk cycles
// each higher plane doubles it
`define LP_CYCLEWIDTH 8

`endif

// ==== src/led_panel_pkg.sv ====
package led_panel_pkg;

	`include "led_panel_settings.svh"

	// index widths
	localparam int ROW_W = $clog2(`LP_ROWS);
	localparam int COL_W = $clog2(`LP_COLUMNS);
	localparam int PLANE_W = $clog2(`LP_BITDEPTH);

	// one pixel column of all segments, rgb per segment
	localparam int WORD_W = 3 * `LP_BITDEPTH * `LP_SEGMENTS;

	typedef enum logic [1:0] {DRV_FETCH, DRV_SHIFT, DRV_LATCH, DRV_SHOW} drv_state_e;

	typedef enum logic [1:0] {SPI_IDLE, SPI_RECV, SPI_DONE} spi_state_e;

endpackage

// ==== src/display_memory.sv ====
`timescale 1ns/100ps

module display_memory (
	input  logic                             sysclk,
	input  logic                             flip,
	input  logic                             wen,
	input  logic [led_panel_pkg::ROW_W-1:0]  wrow,
	input  logic [led_panel_pkg::COL_W-1:0]  wcol,
	input  logic [led_panel_pkg::WORD_W-1:0] wdata,
	input  logic [led_panel_pkg::ROW_W-1:0]  rrow,
	input  logic [led_panel_pkg::COL_W-1:0]  rcol,
	output logic [led_panel_pkg::WORD_W-1:0] rdata
);
	import led_panel_pkg::*;

	// bank bit on top of row and column
	localparam int ADDR_W = 1 + ROW_W + COL_W;

	logic [WORD_W-1:0] mem [0:(2**ADDR_W)-1];
	logic [ADDR_W-1:0] waddr;
	logic [ADDR_W-1:0] raddr;

	// host fills the hidden bank
	assign waddr = {~flip, wrow, wcol};

	// panel reads the shown bank
	assign raddr = {flip, rrow, rcol};

	always_ff @(posedge sysclk) begin
		if (wen) begin
			mem[waddr] <= wdata;
		end
	end

	// one cycle read latency
	always_ff @(posedge sysclk) begin
		rdata <= mem[raddr];
	end

endmodule

// ==== src/display_driver.sv ====
`timescale 1ns/100ps

`include "led_panel_settings.svh"

module display_driver (
	input  logic                             sysclk,
	input  logic                             rst_n,
	output logic [led_panel_pkg::ROW_W-1:0]  rrow,
	output logic [led_panel_pkg::COL_W-1:0]  rcol,
	input  logic [led_panel_pkg::WORD_W-1:0] rdata,
	output logic [3*`LP_SEGMENTS-1:0]        rgb,
	output logic [led_panel_pkg::ROW_W-1:0]  row_addr,
	output logic                             oe_int,
	output logic                             lat,
	output logic                             oclk,
	output logic                             frame_complete
);
	import led_panel_pkg::*;

	// msb plane has the longest show time
	localparam int SHOW_W = $clog2(`LP_CYCLEWIDTH << (`LP_BITDEPTH - 1));
	localparam int SEG_BITS = 3 * `LP_BITDEPTH;

	drv_state_e state;
	logic [ROW_W-1:0] row_cnt;
	logic [PLANE_W-1:0] plane_cnt;
	logic [COL_W-1:0] col_cnt;
	logic phase;
	logic [SHOW_W-1:0] show_cnt;
	logic last_col;
	logic last_plane;
	logic last_row;
	logic show_done;

	assign last_col = (col_cnt == COL_W'(`LP_COLUMNS - 1));
	assign last_plane = (plane_cnt == PLANE_W'(`LP_BITDEPTH - 1));
	assign last_row = (row_cnt == ROW_W'(`LP_ROWS - 1));
	assign show_done = (show_cnt == '0);

	assign rrow = row_cnt;
	// next column is addressed while oclk is high
	assign rcol = col_cnt + COL_W'(phase);

	// rdata holds the current column for both shift cycles
	// rgb[3s+2:3s] is r, g, b of segment s
	always_comb begin
		for (int s = 0; s < `LP_SEGMENTS; s++) begin
			for (int c = 0; c < 3; c++) begin
				rgb[3*s + c] = rdata[SEG_BITS*s + `LP_BITDEPTH*c + plane_cnt];
			end
		end
	end

	// high during the last show cycle, so the swap lands before the next fetch
	assign frame_complete = (state == DRV_SHOW) && show_done && last_plane && last_row;

	always_ff @(posedge sysclk or negedge rst_n) begin
		if (!rst_n) begin
			state <= DRV_FETCH;
			row_cnt <= '0;
			plane_cnt <= '0;
			col_cnt <= '0;
			phase <= 1'b0;
			show_cnt <= '0;
			row_addr <= '0;
			oe_int <= 1'b0;
			lat <= 1'b0;
			oclk <= 1'b0;
		end else begin
			lat <= 1'b0;
			oclk <= 1'b0;
			case (state)
				DRV_FETCH: begin
					// column 0 read is in flight
					col_cnt <= '0;
					phase <= 1'b0;
					state <= DRV_SHIFT;
				end
				DRV_SHIFT: begin
					if (!phase) begin
						oclk <= 1'b1;
						phase <= 1'b1;
					end else begin
						phase <= 1'b0;
						if (last_col) begin
							col_cnt <= '0;
							lat <= 1'b1;
							row_addr <= row_cnt;
							state <= DRV_LATCH;
						end else begin
							col_cnt <= col_cnt + 1'b1;
						end
					end
				end
				DRV_LATCH: begin
					show_cnt <= SHOW_W'((`LP_CYCLEWIDTH << plane_cnt) - 1);
					oe_int <= 1'b1;
					state <= DRV_SHOW;
				end
				DRV_SHOW: begin
					if (show_done) begin
						oe_int <= 1'b0;
						state <= DRV_FETCH;
						// planes inner, rows outer
						if (last_plane) begin
							plane_cnt <= '0;
							row_cnt <= last_row ? '0 : row_cnt + 1'b1;
						end else begin
							plane_cnt <= plane_cnt + 1'b1;
						end
					end else begin
						show_cnt <= show_cnt - 1'b1;
					end
				end
				default: begin
					state <= DRV_FETCH;
				end
			endcase
		end
	end

endmodule

// ==== src/spi_loader.sv ====
`timescale 1ns/100ps

`include "led_panel_settings.svh"

module spi_loader (
	input  logic                             sysclk,
	input  logic                             rst_n,
	input  logic                             sclk,
	input  logic                             ss_n,
	input  logic                             mosi,
	output logic                             miso,
	input  logic                             ready,
	output logic                             wen,
	output logic [led_panel_pkg::ROW_W-1:0]  wrow,
	output logic [led_panel_pkg::COL_W-1:0]  wcol,
	output logic [led_panel_pkg::WORD_W-1:0] wdata,
	output logic                             loaded
);
	import led_panel_pkg::*;

	localparam int BIT_W = $clog2(`LP_BITDEPTH);
	localparam int SEG_IDX_W = $clog2(`LP_SEGMENTS + 1);
	localparam int POS_W = $clog2(WORD_W);
	localparam int SEG_BITS = 3 * `LP_BITDEPTH;

	spi_state_e state;
	logic [2:0] sclk_q;
	logic [1:0] ss_q;
	logic [1:0] mosi_q;
	logic sclk_rise;
	logic sample;
	logic byte_done;
	logic [BIT_W-1:0] bit_cnt;
	logic [1:0] clr_idx;
	logic [SEG_IDX_W-1:0] seg_idx;
	logic [ROW_W-1:0] row_cnt;
	logic [COL_W-1:0] col_cnt;
	logic last_addr;
	logic [POS_W-1:0] byte_pos;
	logic [`LP_BITDEPTH-2:0] shift_q;
	logic [WORD_W-1:0] word_q;

	// two-flop synchronizers, third sclk flop for edge detect
	always_ff @(posedge sysclk or negedge rst_n) begin
		if (!rst_n) begin
			sclk_q <= '0;
			ss_q <= 2'b11;
			mosi_q <= '0;
		end else begin
			sclk_q <= {sclk_q[1:0], sclk};
			ss_q <= {ss_q[0], ss_n};
			mosi_q <= {mosi_q[0], mosi};
		end
	end

	assign sclk_rise = sclk_q[1] && !sclk_q[2];
	assign sample = (state == SPI_RECV) && !ss_q[1] && ready && sclk_rise;
	assign byte_done = sample && (bit_cnt == BIT_W'(`LP_BITDEPTH - 1));
	assign last_addr = (row_cnt == ROW_W'(`LP_ROWS - 1)) && (col_cnt == COL_W'(`LP_COLUMNS - 1));

	// segment 0 in the low bits, r above g above b
	assign byte_pos = POS_W'(SEG_BITS * seg_idx + `LP_BITDEPTH * (2 - clr_idx));

	assign miso = !ss_n && ready;
	assign wrow = row_cnt;
	assign wcol = col_cnt;
	assign wdata = word_q;

	always_ff @(posedge sysclk) begin
		if (sample) begin
			shift_q <= {shift_q[`LP_BITDEPTH-3:0], mosi_q[1]};
		end
		if (byte_done) begin
			word_q[byte_pos +: `LP_BITDEPTH] <= {shift_q, mosi_q[1]};
		end
	end

	always_ff @(posedge sysclk or negedge rst_n) begin
		if (!rst_n) begin
			state <= SPI_IDLE;
			bit_cnt <= '0;
			clr_idx <= '0;
			seg_idx <= '0;
			row_cnt <= '0;
			col_cnt <= '0;
			wen <= 1'b0;
			loaded <= 1'b0;
		end else begin
			wen <= 1'b0;
			loaded <= 1'b0;
			// column carries into row once the word is written
			if (wen) begin
				if (col_cnt == COL_W'(`LP_COLUMNS - 1)) begin
					col_cnt <= '0;
					row_cnt <= row_cnt + 1'b1;
				end else begin
					col_cnt <= col_cnt + 1'b1;
				end
			end
			case (state)
				SPI_IDLE: begin
					bit_cnt <= '0;
					clr_idx <= '0;
					seg_idx <= '0;
					row_cnt <= '0;
					col_cnt <= '0;
					if (!ss_q[1]) begin
						state <= ready ? SPI_RECV : SPI_DONE;
					end
				end
				SPI_RECV: begin
					if (ss_q[1]) begin
						state <= SPI_IDLE;
					end else if (!ready) begin
						state <= SPI_DONE;
					end else if (sclk_rise) begin
						bit_cnt <= bit_cnt + 1'b1;
					end
					if (byte_done) begin
						if (clr_idx == 2'd2) begin
							clr_idx <= '0;
							if (seg_idx == SEG_IDX_W'(`LP_SEGMENTS - 1)) begin
								seg_idx <= '0;
								wen <= 1'b1;
								if (last_addr) begin
									loaded <= 1'b1;
									state <= SPI_DONE;
								end
							end else begin
								seg_idx <= seg_idx + 1'b1;
							end
						end else begin
							clr_idx <= clr_idx + 1'b1;
						end
					end
				end
				SPI_DONE: begin
					// drop everything until ss goes high
					if (ss_q[1]) begin
						state <= SPI_IDLE;
					end
				end
				default: begin
					state <= SPI_IDLE;
				end
			endcase
		end
	end

endmodule

// ==== src/led_panel_top.sv ====
`timescale 1ns/100ps

`include "led_panel_settings.svh"

module led_panel_top (
	input  logic                            sysclk,
	input  logic                            rst_n,
	input  logic                            spi_sclk,
	input  logic                            spi_ss,
	input  logic                            spi_mosi,
	output logic                            spi_miso,
	output logic [3*`LP_SEGMENTS-1:0]       rgb,
	output logic [led_panel_pkg::ROW_W-1:0] a,
	output logic                            oe,
	output logic                            lat,
	output logic                            oclk
);
	import led_panel_pkg::*;

	logic flip;
	logic ready;
	logic frame_complete;
	logic oe_int;
	logic [ROW_W-1:0] row_addr;
	logic [ROW_W-1:0] rrow;
	logic [COL_W-1:0] rcol;
	logic [WORD_W-1:0] rdata;
	logic wen;
	logic loaded;
	logic [ROW_W-1:0] wrow;
	logic [COL_W-1:0] wcol;
	logic [WORD_W-1:0] wdata;

	// panel pins are active low for enable
	assign oe = ~oe_int;
	assign a = row_addr;

	// a held-back frame is swapped in at the next refresh boundary
	always_ff @(posedge sysclk or negedge rst_n) begin
		if (!rst_n) begin
			flip <= 1'b0;
			ready <= 1'b1;
		end else if (frame_complete && !ready) begin
			flip <= ~flip;
			ready <= 1'b1;
		end else if (ready && loaded) begin
			ready <= 1'b0;
		end
	end

	display_driver u_driver (
		.sysclk         (sysclk),
		.rst_n          (rst_n),
		.rrow           (rrow),
		.rcol           (rcol),
		.rdata          (rdata),
		.rgb            (rgb),
		.row_addr       (row_addr),
		.oe_int         (oe_int),
		.lat            (lat),
		.oclk           (oclk),
		.frame_complete (frame_complete)
	);

	display_memory u_memory (
		.sysclk (sysclk),
		.flip   (flip),
		.wen    (wen),
		.wrow   (wrow),
		.wcol   (wcol),
		.wdata  (wdata),
		.rrow   (rrow),
		.rcol   (rcol),
		.rdata  (rdata)
	);

	spi_loader u_loader (
		.sysclk (sysclk),
		.rst_n  (rst_n),
		.sclk   (spi_sclk),
		.ss_n   (spi_ss),
		.mosi   (spi_mosi),
		.miso   (spi_miso),
		.ready  (ready),
		.wen    (wen),
		.wrow   (wrow),
		.wcol   (wcol),
		.wdata  (wdata),
		.loaded (loaded)
	);

endmodule

// ==== test/led_panel_tb.sv ====
`timescale 1ns/100ps

`include "led_panel_settings.svh"

module led_panel_tb;

	localparam int WORD_W = 3 * `LP_BITDEPTH * `LP_SEGMENTS;
	localparam int PIXELS = `LP_ROWS * `LP_COLUMNS;
	localparam int PLANES_PER_REFRESH = `LP_ROWS * `LP_BITDEPTH;
	localparam int SLOTS = 7;
	localparam longint PERIOD_NS = 40;
	// one bit takes 8 sysclk cycles on the SPI link
	localparam longint LOAD_CYCLES = PIXELS * WORD_W * 8;
	localparam longint REFRESH_CYCLES = `LP_ROWS * (`LP_BITDEPTH * (2 * `LP_COLUMNS + 2)
		+ `LP_CYCLEWIDTH * ((1 << `LP_BITDEPTH) - 1));
	localparam longint WATCHDOG_NS = 2 * (4 * LOAD_CYCLES + 8 * REFRESH_CYCLES) * PERIOD_NS;

	logic sysclk;
	logic rst_n;
	logic spi_sclk;
	logic spi_ss;
	logic spi_mosi;
	logic spi_miso;
	logic [3*`LP_SEGMENTS-1:0] rgb;
	logic [2:0] a;
	logic oe;
	logic lat;
	logic oclk;

	// one random frame per load slot
	logic [WORD_W-1:0] frames [SLOTS][PIXELS];
	// panel model state
	logic [3*`LP_SEGMENTS-1:0] col_bits [`LP_COLUMNS];
	logic [WORD_W-1:0] build [PIXELS];
	logic [WORD_W-1:0] shown [PIXELS];
	int oclk_cnt;
	int latch_idx;
	int plane_now;
	int oe_cnt;
	bit oe_armed;
	logic oe_prev;
	int refresh_count;
	int refresh_end_count;
	int load_mark;

	int errors;
	int tests;
	int start_errors;
	logic miso_at_start;
	bit seen_b;
	bit load_done;

	led_panel_top DUT (
		.sysclk   (sysclk),
		.rst_n    (rst_n),
		.spi_sclk (spi_sclk),
		.spi_ss   (spi_ss),
		.spi_mosi (spi_mosi),
		.spi_miso (spi_miso),
		.rgb      (rgb),
		.a        (a),
		.oe       (oe),
		.lat      (lat),
		.oclk     (oclk)
	);

	always #(PERIOD_NS / 2) sysclk = ~sysclk;

	task automatic compare(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			$display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_frame(input string name, input int slot);
		for (int i = 0; i < PIXELS; i++) begin
			compare($sformatf("%s word %0d", name, i), 64'(frames[slot][i]), 64'(shown[i]));
		end
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("test %s finished with %0d errors", name, errors - start_errors);
		start_errors = errors;
	endtask

	task automatic wait_refreshes(input int n);
		int start;
		start = refresh_count;
		wait (refresh_count >= start + n);
	endtask

	task automatic send_byte(input logic [7:0] b);
		for (int i = 7; i >= 0; i--) begin
			spi_mosi = b[i];
			repeat (4) @(negedge sysclk);
			spi_sclk = 1'b1;
			repeat (4) @(negedge sysclk);
			spi_sclk = 1'b0;
		end
	endtask

	// bytes go row by row, then column, then segment 0 r g b, segment 1 r g b
	task automatic send_frame(input int slot);
		logic [WORD_W-1:0] w;
		@(negedge sysclk);
		spi_ss = 1'b0;
		repeat (8) @(negedge sysclk);
		miso_at_start = spi_miso;
		for (int i = 0; i < PIXELS; i++) begin
			w = frames[slot][i];
			for (int s = 0; s < `LP_SEGMENTS; s++) begin
				for (int k = 2; k >= 0; k--) begin
					send_byte(w[24*s + 8*k +: 8]);
				end
			end
		end
		// refresh ends seen up to here come before the loaded pulse
		@(posedge sysclk);
		load_mark = refresh_end_count;
		repeat (8) @(negedge sysclk);
		spi_ss = 1'b1;
		repeat (8) @(negedge sysclk);
	endtask

	// poll miso with short ss pulses until the loader reports ready
	task automatic wait_ready();
		logic r;
		r = 1'b0;
		while (!r) begin
			@(negedge sysclk);
			spi_ss = 1'b0;
			@(negedge sysclk);
			r = spi_miso;
			spi_ss = 1'b1;
			if (!r) begin
				repeat (200) @(negedge sysclk);
			end
		end
	endtask

	// panel model samples mid-cycle where the outputs are stable
	always @(negedge sysclk) begin
		if (rst_n) begin
			if (oclk) begin
				if (oclk_cnt < `LP_COLUMNS) begin
					col_bits[oclk_cnt] = rgb;
				end
				oclk_cnt++;
			end
			if (lat) begin
				compare("scan oclk count", 64'(`LP_COLUMNS), 64'(oclk_cnt));
				compare("scan row address", 64'((latch_idx / `LP_BITDEPTH) % `LP_ROWS), 64'(a));
				plane_now = latch_idx % `LP_BITDEPTH;
				oclk_cnt = 0;
				for (int c = 0; c < `LP_COLUMNS; c++) begin
					for (int s = 0; s < `LP_SEGMENTS; s++) begin
						for (int k = 0; k < 3; k++) begin
							build[int'(a) * `LP_COLUMNS + c][24*s + 8*k + plane_now] =
								col_bits[c][3*s + k];
						end
					end
				end
				oe_cnt = 0;
				oe_armed = 1'b1;
				if (latch_idx % PLANES_PER_REFRESH == PLANES_PER_REFRESH - 1) begin
					shown = build;
					refresh_count++;
				end
				latch_idx++;
			end
			if (!oe) begin
				oe_cnt++;
			end
			if (oe && !oe_prev && oe_armed) begin
				compare("scan oe time", 64'(`LP_CYCLEWIDTH << plane_now), 64'(oe_cnt));
				oe_armed = 1'b0;
				// bank swap lands at the end of the last plane of a refresh
				if ((latch_idx - 1) % PLANES_PER_REFRESH == PLANES_PER_REFRESH - 1) begin
					refresh_end_count++;
				end
			end
			oe_prev = oe;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the run did not finish in time");
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		logic [63:0] r;
		sysclk = 1'b0;
		rst_n = 1'b0;
		spi_sclk = 1'b0;
		spi_ss = 1'b1;
		spi_mosi = 1'b0;
		errors = 0;
		tests = 0;
		start_errors = 0;
		oclk_cnt = 0;
		latch_idx = 0;
		plane_now = 0;
		oe_cnt = 0;
		oe_armed = 1'b0;
		oe_prev = 1'b1;
		refresh_count = 0;
		refresh_end_count = 0;
		load_mark = 0;
		void'($urandom(21));
		for (int f = 0; f < SLOTS; f++) begin
			for (int i = 0; i < PIXELS; i++) begin
				r = {$urandom, $urandom};
				frames[f][i] = r[WORD_W-1:0];
			end
		end

		repeat (16) @(negedge sysclk);
		rst_n = 1'b1;
		@(negedge sysclk);
		compare("reset oe", 64'd1, 64'(oe));
		compare("reset lat", 64'd0, 64'(lat));
		compare("reset oclk", 64'd0, 64'(oclk));
		compare("reset row address", 64'd0, 64'(a));
		compare("reset miso idle", 64'd0, 64'(spi_miso));
		spi_ss = 1'b0;
		@(negedge sysclk);
		compare("reset miso ready", 64'd1, 64'(spi_miso));
		spi_ss = 1'b1;
		finish_test("reset");

		// scan checks run in the panel model the whole time
		wait_refreshes(1);
		finish_test("scan");

		send_frame(0);
		wait_refreshes(2);
		check_frame("initial frame", 0);
		finish_test("initial_frame");

		wait_ready();
		seen_b = 1'b0;
		load_done = 1'b0;
		fork
			begin
				send_frame(1);
				load_done = 1'b1;
			end
			begin
				// the swap follows the first refresh end after the load
				while (!seen_b) begin
					wait_refreshes(1);
					if (load_done && refresh_count > load_mark + 1) begin
						check_frame("double buffer frame B", 1);
						seen_b = 1'b1;
					end else begin
						check_frame("double buffer frame A", 0);
					end
				end
			end
		join
		finish_test("double_buffer");

		wait_ready();
		send_frame(2);
		send_frame(3);
		compare("blocked load miso", 64'd0, 64'(miso_at_start));
		wait_refreshes(2);
		check_frame("blocked load", 2);
		finish_test("ready_blocking");

		for (int f = 4; f < SLOTS; f++) begin
			wait_ready();
			send_frame(f);
			wait_refreshes(2);
			check_frame($sformatf("repeated load %0d", f), f);
		end
		finish_test("repeated_loads");

		$display("tests %0d, errors %0d", tests, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== led_panel.f ====
+incdir+include
src/led_panel_pkg.sv
src/display_memory.sv
src/display_driver.sv
src/spi_loader.sv
src/led_panel_top.sv
test/led_panel_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module led_panel_tb -f led_panel.f -o led_panel_sim \
	&& ./obj_dir/led_panel_sim | tee /dev/stderr | grep -q "Result: PASSED" \
	&& echo "simulation run ok" \
	|| { echo "simulation run not ok"; exit 1; }

exit 0
